//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;	// Data and instruction word
	typedef logic [4:0]  reg_idx_t;
	typedef logic [5:0]  opcode_t;	// instr[31:26]
	typedef logic [5:0]  func_t;	// instr[5:0]
	typedef logic [4:0]  alu_op_t;
	typedef logic [1:0]  pc_src_t;	// 0 pc+1, 1 jf target, 2 rs, 3 jump field
	typedef logic [1:0]  wb_sel_t;	// 0 ALU, 1 data memory, 3 link

	localparam opcode_t OP_RTYPE = 6'd0;
	localparam opcode_t OP_ADDI  = 6'd1;
	localparam opcode_t OP_SUBI  = 6'd2;
	localparam opcode_t OP_MULI  = 6'd3;
	localparam opcode_t OP_ANDI  = 6'd6;	// 4 and 5 were divi and modi
	localparam opcode_t OP_ORI   = 6'd7;
	localparam opcode_t OP_XORI  = 6'd8;
	localparam opcode_t OP_NOT   = 6'd9;
	localparam opcode_t OP_LANDI = 6'd10;
	localparam opcode_t OP_LORI  = 6'd11;
	localparam opcode_t OP_SLLI  = 6'd12;
	localparam opcode_t OP_SRLI  = 6'd13;
	localparam opcode_t OP_MOV   = 6'd14;
	localparam opcode_t OP_LW    = 6'd15;
	localparam opcode_t OP_LI    = 6'd16;
	localparam opcode_t OP_SW    = 6'd18;
	localparam opcode_t OP_OUT   = 6'd20;
	localparam opcode_t OP_JF    = 6'd21;
	localparam opcode_t OP_J     = 6'd22;
	localparam opcode_t OP_JAL   = 6'd23;
	localparam opcode_t OP_HALT  = 6'd24;

	localparam func_t FN_ADD  = 6'd0;
	localparam func_t FN_SUB  = 6'd1;
	localparam func_t FN_MUL  = 6'd2;
	localparam func_t FN_AND  = 6'd5;
	localparam func_t FN_OR   = 6'd6;
	localparam func_t FN_XOR  = 6'd7;
	localparam func_t FN_LAND = 6'd8;
	localparam func_t FN_LOR  = 6'd9;
	localparam func_t FN_SLL  = 6'd10;
	localparam func_t FN_SRL  = 6'd11;
	localparam func_t FN_EQ   = 6'd12;
	localparam func_t FN_NE   = 6'd13;
	localparam func_t FN_LT   = 6'd14;
	localparam func_t FN_LE   = 6'd15;
	localparam func_t FN_GT   = 6'd16;
	localparam func_t FN_GE   = 6'd17;
	localparam func_t FN_JR   = 6'd18;

	localparam alu_op_t ALU_ADD    = 5'b00000;
	localparam alu_op_t ALU_SUB    = 5'b00001;
	localparam alu_op_t ALU_MUL    = 5'b00010;
	localparam alu_op_t ALU_SLL    = 5'b00101;
	localparam alu_op_t ALU_SRL    = 5'b00110;
	localparam alu_op_t ALU_AND    = 5'b01000;
	localparam alu_op_t ALU_OR     = 5'b01001;
	localparam alu_op_t ALU_XOR    = 5'b01010;
	localparam alu_op_t ALU_NOT    = 5'b01011;
	localparam alu_op_t ALU_LAND   = 5'b01100;
	localparam alu_op_t ALU_LOR    = 5'b01101;
	localparam alu_op_t ALU_PASS_A = 5'b01110;
	localparam alu_op_t ALU_PASS_B = 5'b01111;
	localparam alu_op_t ALU_EQ     = 5'b10000;	// Compares all have bit 4 set
	localparam alu_op_t ALU_NE     = 5'b10001;
	localparam alu_op_t ALU_LT     = 5'b10010;
	localparam alu_op_t ALU_LE     = 5'b10011;
	localparam alu_op_t ALU_GT     = 5'b10100;
	localparam alu_op_t ALU_GE     = 5'b10101;

	localparam reg_idx_t LINK_REG = 5'd31;	// jal return address

endpackage

`default_nettype wire

//--- hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  wire cpu_pkg::word_t i_instr,
	input  wire                 i_is_false,	// ALU zero flag
	output logic                o_reg_write,
	output logic                o_mem_write,
	output logic                o_out_write,
	output logic                o_halt,
	output logic                o_reg_alu_op,	// 1 selects rt as ALU operand B, 0 the immediate
	output logic                o_rt_dest,	// 1 writes rt, 0 writes rd
	output cpu_pkg::wb_sel_t    o_wb_sel,
	output cpu_pkg::pc_src_t    o_pc_source,
	output cpu_pkg::alu_op_t    o_alu_op
);
	import cpu_pkg::*;

	opcode_t op;
	func_t   fn;

	assign op = i_instr[31:26];
	assign fn = i_instr[5:0];

	// R type, selected by func
	wire is_rtype = (op == OP_RTYPE);
	wire is_add   = is_rtype & (fn == FN_ADD);
	wire is_sub   = is_rtype & (fn == FN_SUB);
	wire is_mul   = is_rtype & (fn == FN_MUL);
	wire is_and   = is_rtype & (fn == FN_AND);
	wire is_or    = is_rtype & (fn == FN_OR);
	wire is_xor   = is_rtype & (fn == FN_XOR);
	wire is_land  = is_rtype & (fn == FN_LAND);
	wire is_lor   = is_rtype & (fn == FN_LOR);
	wire is_sll   = is_rtype & (fn == FN_SLL);
	wire is_srl   = is_rtype & (fn == FN_SRL);
	wire is_eq    = is_rtype & (fn == FN_EQ);
	wire is_ne    = is_rtype & (fn == FN_NE);
	wire is_lt    = is_rtype & (fn == FN_LT);
	wire is_le    = is_rtype & (fn == FN_LE);
	wire is_gt    = is_rtype & (fn == FN_GT);
	wire is_ge    = is_rtype & (fn == FN_GE);
	wire is_jr    = is_rtype & (fn == FN_JR);

	// I and J type, selected by opcode
	wire is_addi  = (op == OP_ADDI);
	wire is_subi  = (op == OP_SUBI);
	wire is_muli  = (op == OP_MULI);
	wire is_andi  = (op == OP_ANDI);
	wire is_ori   = (op == OP_ORI);
	wire is_xori  = (op == OP_XORI);
	wire is_not   = (op == OP_NOT);
	wire is_landi = (op == OP_LANDI);
	wire is_lori  = (op == OP_LORI);
	wire is_slli  = (op == OP_SLLI);
	wire is_srli  = (op == OP_SRLI);
	wire is_mov   = (op == OP_MOV);
	wire is_lw    = (op == OP_LW);
	wire is_li    = (op == OP_LI);
	wire is_sw    = (op == OP_SW);
	wire is_out   = (op == OP_OUT);
	wire is_jf    = (op == OP_JF);
	wire is_j     = (op == OP_J);
	wire is_jal   = (op == OP_JAL);
	wire is_halt  = (op == OP_HALT);

	wire r_alu = is_add | is_sub | is_mul | is_and | is_or | is_xor | is_land | is_lor |
		is_sll | is_srl | is_eq | is_ne | is_lt | is_le | is_gt | is_ge;
	wire i_alu = is_addi | is_subi | is_muli | is_andi | is_ori | is_xori | is_not |
		is_landi | is_lori | is_slli | is_srli;

	assign o_reg_write  = r_alu | i_alu | is_mov | is_lw | is_li | is_jal;
	assign o_mem_write  = is_sw;
	assign o_out_write  = is_out;
	assign o_halt       = is_halt;
	assign o_reg_alu_op = r_alu | is_mov;
	assign o_rt_dest    = i_alu | is_mov | is_lw | is_li;

	assign o_wb_sel[0]    = is_lw | is_jal;
	assign o_wb_sel[1]    = is_jal;
	assign o_pc_source[0] = is_j | is_jal | (is_jf & i_is_false);
	assign o_pc_source[1] = is_j | is_jal | is_jr;

	// Each line contributes its own code; add, lw and sw fall through as ALU_ADD
	assign o_alu_op = ({5{is_sub | is_subi}} & ALU_SUB)
		| ({5{is_mul | is_muli}} & ALU_MUL)
		| ({5{is_and | is_andi}} & ALU_AND)
		| ({5{is_or | is_ori}} & ALU_OR)
		| ({5{is_xor | is_xori}} & ALU_XOR)
		| ({5{is_not}} & ALU_NOT)
		| ({5{is_land | is_landi}} & ALU_LAND)
		| ({5{is_lor | is_lori}} & ALU_LOR)
		| ({5{is_sll | is_slli}} & ALU_SLL)
		| ({5{is_srl | is_srli}} & ALU_SRL)
		| ({5{is_mov | is_jr | is_jf | is_out}} & ALU_PASS_A)	// jf tests rs through the zero flag
		| ({5{is_li}} & ALU_PASS_B)
		| ({5{is_eq}} & ALU_EQ)
		| ({5{is_ne}} & ALU_NE)
		| ({5{is_lt}} & ALU_LT)
		| ({5{is_le}} & ALU_LE)
		| ({5{is_gt}} & ALU_GT)
		| ({5{is_ge}} & ALU_GE);

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire cpu_pkg::word_t  i_a,
	input  wire cpu_pkg::word_t  i_b,
	input  wire cpu_pkg::alu_op_t i_alu_op,
	output cpu_pkg::word_t       o_result,
	output logic                 o_zero
);
	import cpu_pkg::*;

	logic  [4:0] shamt;
	logic        a_set;
	logic        b_set;
	word_t       product;

	assign shamt   = i_b[4:0];	// Shift amount
	assign a_set   = |i_a;
	assign b_set   = |i_b;
	assign product = i_a * i_b;	// Low 32 bits only

	always_comb begin
		case (i_alu_op)
			ALU_ADD:    o_result = i_a + i_b;
			ALU_SUB:    o_result = i_a - i_b;
			ALU_MUL:    o_result = product;
			ALU_AND:    o_result = i_a & i_b;
			ALU_OR:     o_result = i_a | i_b;
			ALU_XOR:    o_result = i_a ^ i_b;
			ALU_NOT:    o_result = ~i_a;
			ALU_LAND:   o_result = {31'd0, a_set & b_set};
			ALU_LOR:    o_result = {31'd0, a_set | b_set};
			ALU_SLL:    o_result = i_a << shamt;
			ALU_SRL:    o_result = i_a >> shamt;	// Logical, zero fill
			ALU_PASS_A: o_result = i_a;
			ALU_PASS_B: o_result = i_b;
			// Signed compares
			ALU_EQ:     o_result = {31'd0, i_a == i_b};
			ALU_NE:     o_result = {31'd0, i_a != i_b};
			ALU_LT:     o_result = {31'd0, $signed(i_a) < $signed(i_b)};
			ALU_LE:     o_result = {31'd0, $signed(i_a) <= $signed(i_b)};
			ALU_GT:     o_result = {31'd0, $signed(i_a) > $signed(i_b)};
			ALU_GE:     o_result = {31'd0, $signed(i_a) >= $signed(i_b)};
			default:    o_result = '0;
		endcase
	end

	assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire                    i_clk,
	input  wire                    i_reset,
	input  wire cpu_pkg::reg_idx_t i_rs,
	input  wire cpu_pkg::reg_idx_t i_rt,
	input  wire                    i_wr_en,
	input  wire cpu_pkg::reg_idx_t i_wr_idx,
	input  wire cpu_pkg::word_t    i_wr_data,
	output cpu_pkg::word_t         o_rs_data,
	output cpu_pkg::word_t         o_rt_data
);
	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && (i_wr_idx != '0)) begin	// r0 stays zero
			regs[i_wr_idx] <= i_wr_data;
		end
	end

	// Combinational reads
	assign o_rs_data = (i_rs == '0) ? '0 : regs[i_rs];
	assign o_rt_data = (i_rt == '0) ? '0 : regs[i_rt];

endmodule

`default_nettype wire

//--- hw/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
	parameter int DATA_WORDS = 16
) (
	input  wire                 i_clk,
	input  wire                 i_wr_en,
	input  wire cpu_pkg::word_t i_addr,
	input  wire cpu_pkg::word_t i_wr_data,
	output cpu_pkg::word_t      o_rd_data
);
	import cpu_pkg::*;

	localparam int AW = (DATA_WORDS > 1) ? $clog2(DATA_WORDS) : 1;

	word_t          mem [DATA_WORDS];
	word_t          addr_mod;
	logic  [AW-1:0] idx;

	assign addr_mod = i_addr % word_t'(DATA_WORDS);	// Wraps around the depth
	assign idx      = addr_mod[AW-1:0];

	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[idx] <= i_wr_data;
		end
	end

	assign o_rd_data = mem[idx];	// Asynchronous read

endmodule

`default_nettype wire

//--- hw/core_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module core_sequencer (
	input  wire                   i_clk,
	input  wire                   i_reset,
	input  wire                   i_instr_req,
	input  wire cpu_pkg::word_t   i_instr,
	input  wire                   i_reg_write,
	input  wire                   i_mem_write,
	input  wire                   i_out_write,
	input  wire                   i_halt,
	input  wire                   i_rt_dest,
	input  wire cpu_pkg::wb_sel_t i_wb_sel,
	input  wire cpu_pkg::pc_src_t i_pc_source,
	input  wire cpu_pkg::word_t   i_alu_result,
	input  wire cpu_pkg::word_t   i_mem_data,
	input  wire cpu_pkg::word_t   i_rs_data,
	output logic                  o_instr_ack,
	output cpu_pkg::word_t        o_pc,
	output logic                  o_wr_en,
	output cpu_pkg::reg_idx_t     o_wr_idx,
	output cpu_pkg::word_t        o_wr_data,
	output logic                  o_mem_wr_en,
	output logic                  o_out_valid,
	output cpu_pkg::word_t        o_out_data,
	output logic                  o_halted
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ACK,
		S_HALTED
	} seq_state_t;

	seq_state_t state;
	logic       commit;
	word_t      pc_plus1;
	word_t      imm_sext;
	word_t      next_pc;

	assign commit   = (state == S_IDLE) && i_instr_req;	// Instruction executes on this edge
	assign pc_plus1 = o_pc + 32'd1;
	assign imm_sext = {{16{i_instr[15]}}, i_instr[15:0]};

	assign o_wr_en     = commit && i_reg_write;
	assign o_mem_wr_en = commit && i_mem_write;

	always_comb begin
		case (i_pc_source)
			2'd1:    next_pc = imm_sext;	// jf taken, absolute target
			2'd2:    next_pc = i_rs_data;	// jr
			2'd3:    next_pc = {6'd0, i_instr[25:0]};
			default: next_pc = pc_plus1;
		endcase
	end

	always_comb begin
		if (i_wb_sel == 2'd3) begin
			o_wr_idx = LINK_REG;
		end else if (i_rt_dest) begin
			o_wr_idx = i_instr[20:16];
		end else begin
			o_wr_idx = i_instr[15:11];
		end
	end

	always_comb begin
		case (i_wb_sel)
			2'd1:    o_wr_data = i_mem_data;
			2'd3:    o_wr_data = pc_plus1;	// Link value
			default: o_wr_data = i_alu_result;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state       <= S_IDLE;
			o_instr_ack <= 1'b0;
			o_out_valid <= 1'b0;
			o_halted    <= 1'b0;
			o_pc        <= '0;
		end else begin
			o_out_valid <= commit && i_out_write;
			case (state)
				S_IDLE: begin
					if (i_instr_req) begin
						state       <= S_ACK;
						o_instr_ack <= 1'b1;
						o_pc        <= next_pc;
						o_halted    <= i_halt;
					end
				end
				S_ACK: begin
					if (!i_instr_req) begin	// Host finished its half
						o_instr_ack <= 1'b0;
						state       <= o_halted ? S_HALTED : S_IDLE;
					end
				end
				default: state <= S_HALTED;	// Only reset leaves
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (commit && i_out_write) begin
			o_out_data <= i_rs_data;
		end
	end

	ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
		$rose(o_instr_ack) |-> $past(i_instr_req))
		else $error("core_sequencer: ack rose without a request");

	no_ack_halted: assert property (@(posedge i_clk) disable iff (i_reset)
		(state == S_HALTED) |-> !o_instr_ack)
		else $error("core_sequencer: ack high after halt");

endmodule

`default_nettype wire

//--- hw/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
	parameter int DATA_WORDS = 16
) (
	input  wire                 i_clk,
	input  wire                 i_reset,
	input  wire                 i_instr_req,
	input  wire cpu_pkg::word_t i_instr,
	output logic                o_instr_ack,
	output cpu_pkg::word_t      o_pc,
	output logic                o_out_valid,
	output cpu_pkg::word_t      o_out_data,
	output logic                o_halted
);
	import cpu_pkg::*;

	logic     reg_write;
	logic     mem_write;
	logic     out_write;
	logic     halt;
	logic     reg_alu_op;
	logic     rt_dest;
	logic     alu_zero;
	wb_sel_t  wb_sel;
	pc_src_t  pc_source;
	alu_op_t  alu_op;
	word_t    rs_data;
	word_t    rt_data;
	word_t    imm_sext;
	word_t    alu_b;
	word_t    alu_result;
	word_t    mem_data;
	logic     wr_en;
	reg_idx_t wr_idx;
	word_t    wr_data;
	logic     mem_wr_en;

	assign imm_sext = {{16{i_instr[15]}}, i_instr[15:0]};
	assign alu_b    = reg_alu_op ? rt_data : imm_sext;	// Operand B select

	control_unit ctrl_i (
		.i_instr(i_instr), .i_is_false(alu_zero),
		.o_reg_write(reg_write), .o_mem_write(mem_write), .o_out_write(out_write),
		.o_halt(halt), .o_reg_alu_op(reg_alu_op), .o_rt_dest(rt_dest),
		.o_wb_sel(wb_sel), .o_pc_source(pc_source), .o_alu_op(alu_op)
	);

	alu alu_i (
		.i_a(rs_data), .i_b(alu_b), .i_alu_op(alu_op),
		.o_result(alu_result), .o_zero(alu_zero)
	);

	register_file regs_i (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_rs(i_instr[25:21]), .i_rt(i_instr[20:16]),
		.i_wr_en(wr_en), .i_wr_idx(wr_idx), .i_wr_data(wr_data),
		.o_rs_data(rs_data), .o_rt_data(rt_data)
	);

	data_memory #(.DATA_WORDS(DATA_WORDS)) dmem_i (
		.i_clk(i_clk), .i_wr_en(mem_wr_en), .i_addr(alu_result),	// rs + imm
		.i_wr_data(rt_data), .o_rd_data(mem_data)
	);

	core_sequencer seq_i (
		.i_clk(i_clk), .i_reset(i_reset), .i_instr_req(i_instr_req), .i_instr(i_instr),
		.i_reg_write(reg_write), .i_mem_write(mem_write), .i_out_write(out_write),
		.i_halt(halt), .i_rt_dest(rt_dest), .i_wb_sel(wb_sel), .i_pc_source(pc_source),
		.i_alu_result(alu_result), .i_mem_data(mem_data), .i_rs_data(rs_data),
		.o_instr_ack(o_instr_ack), .o_pc(o_pc), .o_wr_en(wr_en), .o_wr_idx(wr_idx),
		.o_wr_data(wr_data), .o_mem_wr_en(mem_wr_en), .o_out_valid(o_out_valid),
		.o_out_data(o_out_data), .o_halted(o_halted)
	);

endmodule

`default_nettype wire

//--- verification/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
	import cpu_pkg::*;

	localparam int ACK_TIMEOUT = 50;	// Cycles per handshake phase
	localparam int HALT_WINDOW = 20;

	logic  clk;
	logic  reset;
	logic  instr_req;
	word_t instr;
	logic  instr_ack;
	word_t pc;
	logic  out_valid;
	word_t out_data;
	logic  halted;

	word_t tbl_instr[$];
	bit    tbl_has_out[$];
	word_t tbl_out[$];
	word_t tbl_pc[$];	// o_pc expected once the row is acknowledged
	word_t model_pc;
	word_t exp_pc;
	int    errors;
	bit    ok;

	cpu_core #(.DATA_WORDS(16)) dut_i (
		.i_clk(clk), .i_reset(reset), .i_instr_req(instr_req), .i_instr(instr),
		.o_instr_ack(instr_ack), .o_pc(pc), .o_out_valid(out_valid),
		.o_out_data(out_data), .o_halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic word_t r_type_word(input int rs, input int rt, input int rd, input func_t fn);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic word_t i_type_word(input opcode_t op, input int rs, input int rt,
			input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic word_t jump_word(input opcode_t op, input int target);
		return {op, 26'(target)};
	endfunction

	task automatic add_row(input word_t w, input bit has_out, input word_t val, input word_t nxt);
		tbl_instr.push_back(w);
		tbl_has_out.push_back(has_out);
		tbl_out.push_back(val);
		tbl_pc.push_back(nxt);
		model_pc = nxt;
	endtask

	// Operation into r3, then out r3
	task automatic op_then_out(input word_t w, input word_t result);
		add_row(w, 1'b0, '0, model_pc + 1);
		add_row(i_type_word(OP_OUT, 3, 0, 0), 1'b1, result, model_pc + 1);
	endtask

	task automatic build_program();
		word_t va;
		word_t vb;
		word_t link;
		va       = 32'd25;
		vb       = 32'hFFFF_FFF9;	// -7
		model_pc = '0;
		add_row(i_type_word(OP_LI, 0, 1, 25), 1'b0, '0, model_pc + 1);
		add_row(i_type_word(OP_LI, 0, 2, -7), 1'b0, '0, model_pc + 1);
		op_then_out(r_type_word(1, 2, 3, FN_ADD), va + vb);
		op_then_out(r_type_word(1, 2, 3, FN_SUB), va - vb);
		op_then_out(r_type_word(1, 2, 3, FN_MUL), va * vb);
		op_then_out(r_type_word(1, 2, 3, FN_AND), va & vb);
		op_then_out(r_type_word(1, 2, 3, FN_OR), va | vb);
		op_then_out(r_type_word(1, 2, 3, FN_XOR), va ^ vb);
		op_then_out(r_type_word(1, 2, 3, FN_LAND), 32'd1);
		op_then_out(r_type_word(0, 0, 3, FN_LOR), 32'd0);
		op_then_out(r_type_word(1, 2, 3, FN_SLL), va << vb[4:0]);
		op_then_out(r_type_word(2, 1, 3, FN_SRL), vb >> va[4:0]);
		op_then_out(i_type_word(OP_ADDI, 1, 3, -100), va + 32'hFFFF_FF9C);
		op_then_out(i_type_word(OP_SUBI, 2, 3, 3), vb - 32'd3);
		op_then_out(i_type_word(OP_MULI, 1, 3, 4), va * 32'd4);
		op_then_out(i_type_word(OP_ANDI, 2, 3, 'hF0), vb & 32'h0000_00F0);
		op_then_out(i_type_word(OP_ORI, 1, 3, 'h8000), va | 32'hFFFF_8000);	// Sign-extended
		op_then_out(i_type_word(OP_XORI, 1, 3, 'hFF), va ^ 32'h0000_00FF);
		op_then_out(i_type_word(OP_NOT, 1, 3, 0), ~va);
		op_then_out(i_type_word(OP_LANDI, 1, 3, 0), 32'd0);
		op_then_out(i_type_word(OP_LORI, 0, 3, 3), 32'd1);
		op_then_out(i_type_word(OP_SLLI, 1, 3, 4), va << 4);
		op_then_out(i_type_word(OP_SRLI, 2, 3, 28), vb >> 28);
		op_then_out(i_type_word(OP_MOV, 2, 3, 0), vb);
		// Signed compares, 25 against -7
		op_then_out(r_type_word(1, 2, 3, FN_EQ), 32'd0);
		op_then_out(r_type_word(1, 2, 3, FN_NE), 32'd1);
		op_then_out(r_type_word(1, 2, 3, FN_LT), 32'd0);
		op_then_out(r_type_word(2, 1, 3, FN_LE), 32'd1);
		op_then_out(r_type_word(1, 2, 3, FN_GT), 32'd1);
		op_then_out(r_type_word(2, 1, 3, FN_GE), 32'd0);
		add_row(i_type_word(OP_SW, 1, 2, -20), 1'b0, '0, model_pc + 1);	// Word 5
		op_then_out(i_type_word(OP_LW, 0, 3, 5), vb);
		op_then_out(i_type_word(OP_LW, 0, 3, 21), vb);	// 21 wraps to word 5
		add_row(jump_word(OP_J, 100), 1'b0, '0, 32'd100);
		add_row(i_type_word(OP_JF, 0, 0, 200), 1'b0, '0, 32'd200);	// r0 is zero, taken
		add_row(i_type_word(OP_JF, 1, 0, 300), 1'b0, '0, model_pc + 1);
		link = model_pc + 1;
		add_row(jump_word(OP_JAL, 400), 1'b0, '0, 32'd400);
		add_row(i_type_word(OP_OUT, 31, 0, 0), 1'b1, link, model_pc + 1);
		add_row(r_type_word(31, 0, 0, FN_JR), 1'b0, '0, link);
		add_row(jump_word(OP_HALT, 0), 1'b0, '0, model_pc + 1);
	endtask

	task automatic compare(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	// Sampled on the falling edge, n counts rising edges
	task automatic wait_for_ack(input logic level, input int limit, output int n);
		n = 0;
		do begin
			@(posedge clk);
			@(negedge clk);
			n++;
		end while (instr_ack !== level && n < limit);
	endtask

	task automatic run_row(input int idx, output bit row_ok);
		int n;
		row_ok = 1'b0;
		@(posedge clk);
		instr_req <= 1'b1;
		instr     <= tbl_instr[idx];
		wait_for_ack(1'b1, ACK_TIMEOUT, n);
		if (instr_ack !== 1'b1) begin
			errors++;
			$display("Timeout: row %0d got no ack within %0d cycles", idx, ACK_TIMEOUT);
			return;
		end
		if (n != 1) begin
			errors++;
			$display("Row %0d: ack came %0d cycles after the request instead of 1", idx, n);
		end
		compare("o_out_valid", word_t'(out_valid), word_t'(tbl_has_out[idx]));
		if (tbl_has_out[idx]) begin
			compare("o_out_data", out_data, tbl_out[idx]);
		end
		repeat (3) begin	// Host keeps req high a while
			@(posedge clk);
			@(negedge clk);
			compare("o_instr_ack", word_t'(instr_ack), 32'd1);
			compare("o_out_valid", word_t'(out_valid), 32'd0);
		end
		@(posedge clk);
		instr_req <= 1'b0;
		wait_for_ack(1'b0, ACK_TIMEOUT, n);
		if (instr_ack !== 1'b0) begin
			errors++;
			$display("Timeout: row %0d ack did not fall within %0d cycles", idx, ACK_TIMEOUT);
			return;
		end
		row_ok = 1'b1;
	endtask

	task automatic probe_after_halt();
		int n;
		@(posedge clk);
		instr_req <= 1'b1;
		instr     <= i_type_word(OP_OUT, 1, 0, 0);
		wait_for_ack(1'b1, HALT_WINDOW, n);	// Expected to run out
		if (instr_ack === 1'b1) begin
			errors++;
			$display("Core acknowledged a request after halt");
		end
		compare("o_out_valid", word_t'(out_valid), 32'd0);
		@(posedge clk);
		instr_req <= 1'b0;
	endtask

	task automatic finish_run();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	initial begin
		errors    = 0;
		reset     = 1'b1;
		instr_req = 1'b0;
		instr     = '0;
		build_program();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		compare("o_instr_ack", word_t'(instr_ack), 32'd0);
		compare("o_out_valid", word_t'(out_valid), 32'd0);
		compare("o_halted", word_t'(halted), 32'd0);
		exp_pc = '0;
		ok     = 1'b1;
		for (int i = 0; i < tbl_instr.size() && ok; i++) begin
			compare("o_pc", pc, exp_pc);
			compare("o_halted", word_t'(halted), 32'd0);
			run_row(i, ok);
			exp_pc = tbl_pc[i];
		end
		if (ok) begin
			compare("o_pc", pc, exp_pc);
			compare("o_halted", word_t'(halted), 32'd1);
			probe_after_halt();
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- build.f
hw/cpu_pkg.sv
hw/control_unit.sv
hw/alu.sv
hw/register_file.sv
hw/data_memory.sv
hw/core_sequencer.sv
hw/cpu_core.sv
verification/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu_core -f build.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "all tests passed" sim.log; then
	exit 0
fi
exit 1
